//--- flist.f
hdl/sos_pkg.sv
hdl/impulse_generator.sv
hdl/ping_sequencer.sv
hdl/onset_detector.sv
hdl/echo_collector.sv
hdl/sos_ranger_top.sv
verification/tb_sos_ranger.sv

//--- hdl/echo_collector.sv
`timescale 1ns/1ps
`default_nettype none

module echo_collector (
  input  logic                                       clk_in,
  input  logic                                       rst_in,
  input  logic                                       listen_start,
  input  logic                                       listen_done,
  input  sos_pkg::echo_hit_t [sos_pkg::NUM_MICS-1:0] hits,
  output logic                                       report_valid,
  output sos_pkg::range_report_t                     report
);

  logic [sos_pkg::NUM_MICS-1:0]         mask;
  logic [sos_pkg::NUM_MICS-1:0][7:0]    delays;

  logic                                 best_valid;
  logic [$clog2(sos_pkg::NUM_MICS)-1:0] best_ch;
  logic [7:0]                           best_delay;

  // smallest delay wins, strict compare keeps the lowest index on a tie
  always_comb begin
    best_valid = 1'b0;
    best_ch    = '0;
    best_delay = '0;
    for (int i = 0; i < sos_pkg::NUM_MICS; i++) begin
      if (mask[i] && (!best_valid || (delays[i] < best_delay))) begin
        best_valid = 1'b1;
        best_ch    = i[$clog2(sos_pkg::NUM_MICS)-1:0];
        best_delay = delays[i];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      mask         <= '0;
      report_valid <= 1'b0;
    end else begin
      report_valid <= listen_done;
      if (listen_start) begin
        mask <= '0;  // new ping
      end
      for (int i = 0; i < sos_pkg::NUM_MICS; i++) begin
        if (hits[i].hit) begin
          mask[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (listen_start) begin
      delays <= '0;
    end
    for (int i = 0; i < sos_pkg::NUM_MICS; i++) begin
      if (hits[i].hit) begin
        delays[i] <= hits[i].delay;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (listen_done) begin
      report <= '{hit_mask:      mask,
                  delays:        delays,
                  nearest_valid: best_valid,
                  nearest_ch:    best_ch,
                  nearest_delay: best_delay};
    end
  end

endmodule

`default_nettype wire

//--- hdl/impulse_generator.sv
`timescale 1ns/1ps
`default_nettype none

module impulse_generator (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               step_in,
  input  logic               start,
  output logic               done,
  output logic signed [15:0] amp_out
);

  logic armed;   // start seen, burst begins on the next step
  logic firing;  // burst on the speaker
  logic [$clog2(sos_pkg::PULSE_STEPS)-1:0] step_cnt;
  logic last_step;

  // the step that closes the final burst period
  assign last_step = firing && step_in &&
                     (step_cnt == ($clog2(sos_pkg::PULSE_STEPS))'(sos_pkg::PULSE_STEPS - 1));

  assign done = last_step;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      armed    <= 1'b0;
      firing   <= 1'b0;
      step_cnt <= '0;
      amp_out  <= '0;
    end else begin
      if (start && !firing) begin
        armed <= 1'b1;
      end

      if (armed && step_in) begin
        // first step after start, speaker goes loud
        armed    <= 1'b0;
        firing   <= 1'b1;
        step_cnt <= '0;
        amp_out  <= sos_pkg::PULSE_AMP;
      end else if (firing && step_in) begin
        if (last_step) begin
          firing  <= 1'b0;
          amp_out <= '0;  // back to silence
        end else begin
          step_cnt <= step_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/onset_detector.sv
`timescale 1ns/1ps
`default_nettype none

module onset_detector (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  sos_pkg::listen_step_t listen_step,
  input  logic signed [7:0]     sample,
  output sos_pkg::echo_hit_t    hit
);

  // wide enough for WINDOW_SIZE samples of magnitude 128, and 1.5x of that
  typedef logic [$clog2(sos_pkg::WINDOW_SIZE)+7:0] energy_t;

  logic [7:0] raw;
  logic [7:0] mag;
  logic       first;       // sample_ix 0 of a ping
  logic       window_end;  // last sample of a window
  logic       armed;       // no hit yet in this ping
  logic       onset;

  energy_t cur_e, prev_e, pprev_e;
  energy_t sum_e, hist1, hist2;

  logic       found;
  logic       hit_q;
  logic [7:0] delay_q;

  assign raw = sample;
  assign mag = raw[7] ? (~raw + 8'd1) : raw;  // -128 gives 128

  assign first      = listen_step.sample_ix == 8'd0;
  assign window_end = &listen_step.sample_ix[$clog2(sos_pkg::WINDOW_SIZE)-1:0];
  assign armed      = first || !found;

  // energies count as zero at the start of a ping
  assign sum_e = (first ? energy_t'(0) : cur_e) + energy_t'(mag);
  assign hist1 = first ? energy_t'(0) : prev_e;
  assign hist2 = first ? energy_t'(0) : pprev_e;

  // louder than the last window and more than 1.5x the one before
  assign onset = (sum_e > hist1) && (sum_e > hist2 + (hist2 >> 1));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      found <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      hit_q <= 1'b0;
      if (listen_step.valid) begin
        if (first) begin
          found <= 1'b0;
        end
        if (window_end && onset && armed) begin
          hit_q <= 1'b1;
          found <= 1'b1;  // one report per ping
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (listen_step.valid) begin
      if (window_end) begin
        cur_e   <= '0;
        delay_q <= listen_step.sample_ix & ~8'(sos_pkg::WINDOW_SIZE - 1);
        if (!(onset && armed)) begin
          prev_e  <= sum_e;  // shift window history
          pprev_e <= hist1;
        end
      end else begin
        cur_e <= sum_e;
        if (first) begin
          prev_e  <= '0;
          pprev_e <= '0;
        end
      end
    end
  end

  assign hit = '{hit: hit_q, delay: delay_q};

endmodule

`default_nettype wire

//--- hdl/ping_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ping_sequencer (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  step_in,
  input  logic                  trigger,
  input  logic                  done,
  output logic                  start,
  output logic                  busy,
  output sos_pkg::listen_step_t listen_step,
  output logic                  listen_start,
  output logic                  listen_done
);

  typedef enum logic [1:0] {
    ST_IDLE,    // waiting for a trigger
    ST_AWAIT,   // burst in progress
    ST_LISTEN,  // channels take samples
    ST_DRAIN    // let the last hits settle, then close the ping
  } state_t;

  state_t state;

  // shared by every channel so window edges line up
  logic [7:0] sample_cnt;
  logic       listen_valid;
  logic       last_sample;

  assign listen_valid = (state == ST_LISTEN) && step_in;
  assign last_sample  = sample_cnt == 8'(sos_pkg::MAX_DELAY - 1);

  assign listen_step  = '{valid: listen_valid, sample_ix: sample_cnt};
  assign listen_start = listen_valid && (sample_cnt == 8'd0);

  assign busy = state != ST_IDLE;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state       <= ST_IDLE;
      start       <= 1'b0;
      listen_done <= 1'b0;
      sample_cnt  <= '0;
    end else begin
      start       <= 1'b0;
      listen_done <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (trigger) begin
            start <= 1'b1;
            state <= ST_AWAIT;
          end
        end

        ST_AWAIT: begin
          if (done) begin
            sample_cnt <= '0;
            state      <= ST_LISTEN;
          end
        end

        ST_LISTEN: begin
          if (listen_valid) begin
            if (last_sample) begin
              sample_cnt <= '0;
              state      <= ST_DRAIN;
            end else begin
              sample_cnt <= sample_cnt + 8'd1;
            end
          end
        end

        ST_DRAIN: begin
          // first cycle raises listen_done, second returns to idle
          if (listen_done) begin
            state <= ST_IDLE;
          end else begin
            listen_done <= 1'b1;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/sos_pkg.sv
package sos_pkg;

  // channel count and listening geometry
  localparam int NUM_MICS    = 4;
  localparam int WINDOW_SIZE = 32;   // samples per energy window
  localparam int MAX_DELAY   = 256;  // listening length in samples, whole windows

  // speaker burst
  localparam int PULSE_STEPS = 4;
  localparam logic signed [15:0] PULSE_AMP = 16'sd16000;

  typedef logic signed [7:0] sample_t;

  // one signed sample per microphone
  typedef sample_t [NUM_MICS-1:0] mic_bus_t;

  // one listening sample, broadcast to every channel
  typedef struct packed {
    logic       valid;
    logic [7:0] sample_ix;  // samples since listening began
  } listen_step_t;

  // a single channel's detection
  typedef struct packed {
    logic       hit;
    logic [7:0] delay;  // start sample of the onset window
  } echo_hit_t;

  typedef struct packed {
    logic [NUM_MICS-1:0]                hit_mask;
    logic [NUM_MICS-1:0][7:0]           delays;
    logic                               nearest_valid;
    logic [$clog2(NUM_MICS)-1:0]        nearest_ch;
    logic [7:0]                         nearest_delay;
  } range_report_t;

endpackage

//--- hdl/sos_ranger_top.sv
`timescale 1ns/1ps
`default_nettype none

module sos_ranger_top (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   step_in,
  input  logic                   trigger,
  input  sos_pkg::mic_bus_t      mic_in,
  output logic signed [15:0]     amp_out,
  output logic                   busy,
  output logic                   report_valid,
  output sos_pkg::range_report_t report
);

  logic                                       start;
  logic                                       done;
  sos_pkg::listen_step_t                      listen_step;
  logic                                       listen_start;
  logic                                       listen_done;
  sos_pkg::echo_hit_t [sos_pkg::NUM_MICS-1:0] hits;

  ping_sequencer seq0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .step_in      (step_in),
    .trigger      (trigger),
    .done         (done),
    .start        (start),
    .busy         (busy),
    .listen_step  (listen_step),
    .listen_start (listen_start),
    .listen_done  (listen_done)
  );

  impulse_generator imp0 (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .step_in (step_in),
    .start   (start),
    .done    (done),
    .amp_out (amp_out)
  );

  // one detector per microphone, all on the same sample counter
  for (genvar i = 0; i < sos_pkg::NUM_MICS; i++) begin : g_mic
    onset_detector det (
      .clk_in      (clk_in),
      .rst_in      (rst_in),
      .listen_step (listen_step),
      .sample      (mic_in[i]),
      .hit         (hits[i])
    );
  end

  echo_collector col0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .listen_start (listen_start),
    .listen_done  (listen_done),
    .hits         (hits),
    .report_valid (report_valid),
    .report       (report)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_sos_ranger \
  -Mdir obj_dir -o tb_sos_ranger -f flist.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sos_ranger > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }

//--- verification/tb_sos_ranger.sv
`timescale 1ns/1ps

module tb_sos_ranger;

  localparam int W           = sos_pkg::WINDOW_SIZE;
  localparam int NUM_WIN     = sos_pkg::MAX_DELAY / W;
  localparam int CH_W        = $clog2(sos_pkg::NUM_MICS);
  localparam int STEP_DIV    = 4;  // clock cycles per step_in
  localparam int PING_STEPS  = sos_pkg::PULSE_STEPS + 1 + sos_pkg::MAX_DELAY;
  localparam int PING_CYCLES = 2 + STEP_DIV * PING_STEPS + 8;
  localparam int NUM_PINGS   = 9;   // reset test counts as one
  localparam int MAX_CYCLES  = (NUM_PINGS + 2) * PING_CYCLES;
  localparam int REPORT_WAIT = 16;

  logic                   clk_in;
  logic                   rst_in;
  logic                   step_in;
  logic                   trigger;
  sos_pkg::mic_bus_t      mic_in;
  logic signed [15:0]     amp_out;
  logic                   busy;
  logic                   report_valid;
  sos_pkg::range_report_t report;

  logic signed [7:0]      samples [sos_pkg::NUM_MICS][sos_pkg::MAX_DELAY];
  sos_pkg::range_report_t exp_q[$];
  logic [15:0]            lfsr_state;
  int amp_cycles;
  int reports_seen;
  int reports_expected;
  int value_errors;
  int report_errors;
  int timeouts;
  int cycles;

  sos_ranger_top dut0 (.*);

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // window rule per channel, then the nearest channel over all hits
  function automatic sos_pkg::range_report_t expected_report();
    sos_pkg::range_report_t r;
    int e;
    int prev;
    int pprev;
    int s;
    bit found;
    r = '0;
    for (int c = 0; c < sos_pkg::NUM_MICS; c++) begin
      prev  = 0;
      pprev = 0;
      found = 1'b0;
      for (int k = 0; k < NUM_WIN; k++) begin
        e = 0;
        for (int j = 0; j < W; j++) begin
          s = int'(samples[c][k * W + j]);
          e += (s < 0) ? -s : s;
        end
        if (!found && e > prev && 2 * e > 3 * pprev) begin  // 1.5x kept in integers
          found         = 1'b1;
          r.hit_mask[c] = 1'b1;
          r.delays[c]   = 8'(k * W);
        end
        pprev = prev;
        prev  = e;
      end
      if (found && (!r.nearest_valid || r.delays[c] < r.nearest_delay)) begin
        r.nearest_valid = 1'b1;
        r.nearest_ch    = CH_W'(c);
        r.nearest_delay = r.delays[c];
      end
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      value_errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic clear_samples();
    for (int c = 0; c < sos_pkg::NUM_MICS; c++) begin
      for (int i = 0; i < sos_pkg::MAX_DELAY; i++) samples[c][i] = '0;
    end
  endtask

  // loud alternating burst from sample at with low noise after it
  task automatic put_echo(input int c, input int at);
    logic signed [2:0] n;
    for (int i = at; i < sos_pkg::MAX_DELAY; i++) begin
      if (i < at + 24) begin
        samples[c][i] = (i % 2 == 0) ? 8'sd90 : -8'sd90;
      end else begin
        n = 3'(take_bits(3));
        samples[c][i] = 8'(n);
      end
    end
  endtask

  // quiet prefix of whole windows, then a random level per window
  task automatic put_random(input int c);
    int quiet;
    int level;
    logic [7:0] r;
    quiet = take_bits(3);
    for (int w = quiet; w < NUM_WIN; w++) begin
      level = take_bits(3);
      for (int j = 0; j < W; j++) begin
        r = 8'(take_bits(8));
        samples[c][w * W + j] = (level == 0) ? 8'sd0 : ($signed(r) >>> (7 - level));
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_in);
    rst_in = 1'b1;
    repeat (5) @(negedge clk_in);
    rst_in = 1'b0;
  endtask

  task automatic drive_step(input sos_pkg::mic_bus_t m, input logic trig);
    @(negedge clk_in);
    step_in = 1'b1;
    mic_in  = m;
    @(negedge clk_in);
    step_in = 1'b0;
    trigger = trig;  // lands while busy
    @(negedge clk_in);
    trigger = 1'b0;
    @(negedge clk_in);
  endtask

  task automatic start_ping();
    @(negedge clk_in);
    amp_cycles = 0;
    trigger    = 1'b1;
    @(negedge clk_in);
    trigger = 1'b0;
    check_value("busy after trigger", 64'(busy), 64'd1);
  endtask

  task automatic wait_report();
    int n;
    n = 0;
    while (reports_seen < reports_expected && n < REPORT_WAIT) begin
      @(posedge clk_in);
      n++;
    end
    if (reports_seen < reports_expected) begin
      report_errors++;
      $display("missing report: none within %0d cycles after listening ended", n);
      exp_q.delete();
      reports_expected = reports_seen;
    end
  endtask

  task automatic run_ping(input int extra_trig_ix);
    sos_pkg::mic_bus_t m;
    start_ping();
    repeat (sos_pkg::PULSE_STEPS + 1) drive_step('0, 1'b0);  // burst and its closing step
    exp_q.push_back(expected_report());
    reports_expected++;
    for (int ix = 0; ix < sos_pkg::MAX_DELAY; ix++) begin
      for (int c = 0; c < sos_pkg::NUM_MICS; c++) m[c] = samples[c][ix];
      drive_step(m, ix == extra_trig_ix);
    end
    wait_report();
    @(negedge clk_in);
    check_value("busy after report", 64'(busy), 64'd0);
    check_value("burst cycles", 64'(amp_cycles), 64'(sos_pkg::PULSE_STEPS * STEP_DIV));
  endtask

  task automatic reset_mid_ping();
    start_ping();
    repeat (2) drive_step('0, 1'b0);
    apply_reset();
    check_value("busy after reset", 64'(busy), 64'd0);
    check_value("report_valid after reset", 64'(report_valid), 64'd0);
    check_value("amp_out after reset", 64'(amp_out), 64'd0);
    amp_cycles = 0;
    repeat (PING_STEPS) drive_step('0, 1'b0);  // a stale ping would report in here
    check_value("burst cycles after reset", 64'(amp_cycles), 64'd0);
  endtask

  task automatic finish_run();
    $display("value errors %0d, report errors %0d, timeouts %0d",
             value_errors, report_errors, timeouts);
    if (value_errors + report_errors + timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // burst level and report compare on the falling edge
  initial begin
    sos_pkg::range_report_t want;
    forever begin
      @(negedge clk_in);
      if (amp_out !== '0) begin
        amp_cycles++;
        check_value("amp_out level", 64'(amp_out), 64'(sos_pkg::PULSE_AMP));
      end
      if (report_valid === 1'b1) begin
        reports_seen++;
        if (exp_q.size() == 0) begin
          report_errors++;
          $display("extra report at %0t while no ping was waiting for one", $time);
        end else begin
          want = exp_q.pop_front();
          check_value("hit_mask", 64'(report.hit_mask), 64'(want.hit_mask));
          check_value("delays", 64'(report.delays), 64'(want.delays));
          check_value("nearest", 64'({report.nearest_valid, report.nearest_ch,
                                      report.nearest_delay}),
                      64'({want.nearest_valid, want.nearest_ch, want.nearest_delay}));
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_in);
      cycles++;
    end
    timeouts++;
    $display("timeout: run still going after %0d cycles", cycles);
    finish_run();
  end

  initial begin
    rst_in           = 1'b1;
    trigger          = 1'b0;
    step_in          = 1'b0;
    mic_in           = '0;
    lfsr_state       = 16'd58;
    amp_cycles       = 0;
    reports_seen     = 0;
    reports_expected = 0;
    value_errors     = 0;
    report_errors    = 0;
    timeouts         = 0;
    apply_reset();

    clear_samples();  // distinct echoes with a trigger while busy
    put_echo(0, 70);
    put_echo(1, 150);
    put_echo(2, 40);
    put_echo(3, 200);
    run_ping(100);

    clear_samples();  // channel 1 silent
    put_echo(0, 70);
    put_echo(2, 120);
    put_echo(3, 45);
    run_ping(-1);

    clear_samples();
    run_ping(-1);

    clear_samples();  // channels 0 and 3 share one stream
    put_echo(0, 120);
    for (int i = 0; i < sos_pkg::MAX_DELAY; i++) samples[3][i] = samples[0][i];
    put_echo(1, 180);
    put_echo(2, 230);
    run_ping(-1);

    reset_mid_ping();
    clear_samples();  // first and last window
    put_echo(0, 5);
    put_echo(1, 33);
    put_echo(2, 250);
    put_echo(3, 100);
    run_ping(-1);

    repeat (3) begin
      clear_samples();
      for (int c = 0; c < sos_pkg::NUM_MICS; c++) put_random(c);
      run_ping(-1);
    end
    finish_run();
  end

endmodule
